// ==== tb.f ====
rtl/recovery_pkg.sv
rtl/recovery_pec.sv
rtl/payload_fifo.sv
rtl/recovery_receiver.sv
rtl/recovery_executor.sv
rtl/recovery_transmitter.sv
rtl/recovery_handler.sv
sim/recovery_handler_sva.sv
sim/tb_recovery_handler.sv

// ==== Bender.yml ====
package:
  name: recovery_handler

sources:
  - files:
      - rtl/recovery_pkg.sv
      - rtl/recovery_pec.sv
      - rtl/payload_fifo.sv
      - rtl/recovery_receiver.sv
      - rtl/recovery_executor.sv
      - rtl/recovery_transmitter.sv
      - rtl/recovery_handler.sv
  - target: simulation
    files:
      - sim/recovery_handler_sva.sv
      - sim/tb_recovery_handler.sv

// ==== sim/tb_recovery_handler.sv ====
// Recovery handler testbench
`timescale 1ns/1ps

module tb_recovery_handler;
  import recovery_pkg::*;

  localparam int unsigned ClkPeriod = 40;
  localparam int unsigned ResetCycles = 10;
  localparam int unsigned NumEntries = 16;
  localparam int unsigned EntryCycles = 400;
  localparam byte_t WrAddr = 8'h42;
  localparam byte_t RdAddr = 8'h43;

  localparam logic [1:0] KindWrite = 2'd0;
  localparam logic [1:0] KindRead = 2'd1;
  localparam logic [1:0] KindDrain = 2'd2;

  typedef struct packed {
    logic [1:0]   kind;
    byte_t        status;
    byte_t        cmd;
    rec_len_t     len;
    rec_payload_t data;
    logic         bad_pec;
    rec_len_t     exp_len;
    rec_payload_t exp_data;
    logic         exp_active;
  } entry_t;

  logic  clk_i;
  logic  rst_n_i;
  byte_t dev_status_i;
  logic  rx_valid_i;
  logic  rx_ready_o;
  byte_t rx_data_i;
  logic  bus_start_i;
  logic  bus_stop_i;
  byte_t bus_addr_i;
  logic  bus_addr_valid_i;
  logic  tx_valid_o;
  logic  tx_ready_i;
  byte_t tx_data_o;
  logic  tx_nack_i;
  logic  payload_valid_o;
  logic  payload_ready_i;
  byte_t payload_data_o;
  logic  payload_available_o;
  logic  image_activated_o;

  entry_t table_q[$];
  byte_t  tx_q[$];
  byte_t  payload_q[$];
  byte_t  exp_payload_q[$];
  integer seed = 21;
  int     errors = 0;
  int     passed = 0;
  int     avail_cycles = 0;

  recovery_handler dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    repeat (ResetCycles + NumEntries * EntryCycles) @(posedge clk_i);
    $display("Timeout: the run did not finish within the cycle limit");
    $display("STATUS: FAIL");
    $finish;
  end

  // Random ready on both output streams, bytes logged just before their transfer edge
  initial begin : stream_monitor
    logic [31:0] rnd;
    forever begin
      @(negedge clk_i);
      if (rst_n_i) begin
        rnd = $random(seed);
        tx_ready_i = rnd[0];
        payload_ready_i = rnd[1];
        if (tx_valid_o && tx_ready_i) begin
          tx_q.push_back(tx_data_o);
        end
        if (payload_valid_o && payload_ready_i) begin
          payload_q.push_back(payload_data_o);
        end
        if (payload_available_o) begin
          avail_cycles++;
        end
      end
    end
  end

  // SMBus CRC-8, one data bit at a time
  function automatic byte_t crc8(byte_t crc, byte_t b);
    logic fb;
    for (int i = 7; i >= 0; i--) begin
      fb = crc[7] ^ b[i];
      crc = {crc[6:0], 1'b0} ^ (fb ? 8'h07 : 8'h00);
    end
    return crc;
  endfunction

  function automatic string kind_name(logic [1:0] kind);
    case (kind)
      KindWrite: return "write";
      KindRead:  return "read";
      default:   return "drain";
    endcase
  endfunction

  task automatic add_entry(input logic [1:0] kind, input byte_t status, input byte_t cmd,
                           input rec_len_t len, input rec_payload_t data, input logic bad_pec,
                           input rec_len_t exp_len, input rec_payload_t exp_data,
                           input logic exp_active);
    entry_t e;
    e.kind = kind;
    e.status = status;
    e.cmd = cmd;
    e.len = len;
    e.data = data;
    e.bad_pec = bad_pec;
    e.exp_len = exp_len;
    e.exp_data = exp_data;
    e.exp_active = exp_active;
    table_q.push_back(e);
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %02h expected %02h", $time, name, got, exp);
      errors++;
    end
  endtask

  // All bus tasks start and end on a falling edge
  task automatic bus_event(input logic start, input logic stop, input logic addr_vld,
                           input byte_t addr);
    bus_start_i = start;
    bus_stop_i = stop;
    bus_addr_valid_i = addr_vld;
    bus_addr_i = addr;
    @(negedge clk_i);
    bus_start_i = 1'b0;
    bus_stop_i = 1'b0;
    bus_addr_valid_i = 1'b0;
  endtask

  task automatic send_byte(input byte_t b);
    logic taken;
    taken = 1'b0;
    rx_valid_i = 1'b1;
    rx_data_i = b;
    while (!taken) begin
      taken = rx_ready_o;
      @(negedge clk_i);
    end
    rx_valid_i = 1'b0;
  endtask

  task automatic wait_rx_ready();
    while (!rx_ready_o) begin
      @(negedge clk_i);
    end
  endtask

  task automatic run_write(input entry_t e);
    byte_t pkt[$];
    byte_t pec;
    int    avail_start;
    logic  accepted;
    avail_start = avail_cycles;
    pkt.push_back(e.cmd);
    pkt.push_back(e.len[7:0]);
    pkt.push_back(e.len[15:8]);
    for (int i = 0; i < e.len; i++) begin
      pkt.push_back(e.data[8*i +: 8]);
    end
    pec = crc8(8'h00, WrAddr);
    bus_event(1'b1, 1'b0, 1'b0, 8'h00);
    bus_event(1'b0, 1'b0, 1'b1, WrAddr);
    foreach (pkt[i]) begin
      pec = crc8(pec, pkt[i]);
      send_byte(pkt[i]);
    end
    send_byte(e.bad_pec ? ~pec : pec);
    bus_event(1'b0, 1'b1, 1'b0, 8'h00);
    wait_rx_ready();
    @(negedge clk_i);
    accepted = (e.status == RecoveryMode) && !e.bad_pec && (e.len <= MaxPayload);
    if (accepted && e.cmd == CmdIndirectData && e.len != 0) begin
      for (int i = 0; i < e.len; i++) begin
        exp_payload_q.push_back(e.data[8*i +: 8]);
      end
      if (avail_cycles == avail_start) begin
        $display("Fail at %0t: payload_available_o never rose after the image write", $time);
        errors++;
      end
    end
  endtask

  task automatic run_read(input entry_t e);
    int       need;
    rec_len_t got_len;
    byte_t    pec;
    byte_t    exp_b;
    tx_q.delete();
    bus_event(1'b1, 1'b0, 1'b0, 8'h00);
    bus_event(1'b0, 1'b0, 1'b1, WrAddr);
    send_byte(e.cmd);
    bus_event(1'b1, 1'b0, 1'b0, 8'h00);
    bus_event(1'b0, 1'b0, 1'b1, RdAddr);
    if (e.status != RecoveryMode) begin
      // Quiet window, nothing may be sent
      repeat (20) @(negedge clk_i);
      if (tx_q.size() != 0) begin
        $display("Fail at %0t: %0d bytes sent while recovery mode was off", $time,
                 tx_q.size());
        errors++;
      end
    end else begin
      need = 3;
      while (tx_q.size() < need) begin
        @(negedge clk_i);
        if (tx_q.size() >= 2) begin
          got_len = {tx_q[1], tx_q[0]};
          need = (got_len > MaxPayload) ? 3 + MaxPayload : 3 + got_len;
        end
      end
      @(negedge clk_i);
      if (tx_q.size() != 3 + e.exp_len) begin
        $display("Fail at %0t: tx_data_o byte count got %0d expected %0d", $time,
                 tx_q.size(), 3 + e.exp_len);
        errors++;
      end else begin
        pec = crc8(8'h00, RdAddr);
        check_byte("tx_data_o length low", tx_q[0], e.exp_len[7:0]);
        pec = crc8(pec, e.exp_len[7:0]);
        check_byte("tx_data_o length high", tx_q[1], e.exp_len[15:8]);
        pec = crc8(pec, e.exp_len[15:8]);
        for (int i = 0; i < e.exp_len; i++) begin
          exp_b = e.exp_data[8*i +: 8];
          check_byte($sformatf("tx_data_o data %0d", i), tx_q[2 + i], exp_b);
          pec = crc8(pec, exp_b);
        end
        check_byte("tx_data_o PEC", tx_q[2 + e.exp_len], pec);
      end
    end
    bus_event(1'b0, 1'b1, 1'b0, 8'h00);
    wait_rx_ready();
  endtask

  task automatic run_drain(input entry_t e);
    while (payload_available_o) begin
      @(negedge clk_i);
    end
    @(negedge clk_i);
    if (payload_q.size() != e.exp_len || payload_q.size() != exp_payload_q.size()) begin
      $display("Fail at %0t: payload_data_o count got %0d expected %0d", $time,
               payload_q.size(), e.exp_len);
      errors++;
    end else begin
      foreach (payload_q[i]) begin
        check_byte($sformatf("payload_data_o byte %0d", i), payload_q[i], exp_payload_q[i]);
      end
    end
    payload_q.delete();
    exp_payload_q.delete();
  endtask

  task automatic build_table();
    add_entry(KindWrite, 8'h00, CmdRecoveryCtrl, 16'd3, 64'h0F2211, 1'b0, 16'd0, '0, 1'b0);
    add_entry(KindRead, 8'h00, CmdProtCap, 16'd0, '0, 1'b0, 16'd0, '0, 1'b0);
    add_entry(KindRead, 8'h03, CmdProtCap, 16'd0, '0, 1'b0, 16'd8, ProtCapValue, 1'b0);
    add_entry(KindRead, 8'h03, CmdRecoveryCtrl, 16'd0, '0, 1'b0, 16'd3, '0, 1'b0);
    add_entry(KindWrite, 8'h03, CmdRecoveryCtrl, 16'd3, 64'h01B2A1, 1'b0, 16'd0, '0, 1'b0);
    add_entry(KindRead, 8'h03, CmdRecoveryCtrl, 16'd0, '0, 1'b0, 16'd3, 64'h01B2A1, 1'b0);
    add_entry(KindWrite, 8'h03, CmdRecoveryCtrl, 16'd3, 64'h0FC3C4, 1'b1, 16'd0, '0, 1'b0);
    add_entry(KindRead, 8'h03, CmdRecoveryCtrl, 16'd0, '0, 1'b0, 16'd3, 64'h01B2A1, 1'b0);
    add_entry(KindWrite, 8'h03, CmdRecoveryCtrl, 16'd2, 64'h0F6655, 1'b0, 16'd0, '0, 1'b0);
    add_entry(KindRead, 8'h03, CmdRecoveryCtrl, 16'd0, '0, 1'b0, 16'd3, 64'h01B2A1, 1'b0);
    add_entry(KindWrite, 8'h03, CmdRecoveryCtrl, 16'd3, 64'h0F5AA5, 1'b0, 16'd0, '0, 1'b1);
    add_entry(KindRead, 8'h03, CmdRecoveryCtrl, 16'd0, '0, 1'b0, 16'd3, 64'h0F5AA5, 1'b1);
    add_entry(KindWrite, 8'h03, CmdIndirectData, 16'd8, 64'h8877665544332211, 1'b0, 16'd0,
              '0, 1'b1);
    add_entry(KindWrite, 8'h03, CmdIndirectData, 16'd5, 64'hE5E4E3E2E1, 1'b0, 16'd0, '0,
              1'b1);
    add_entry(KindDrain, 8'h03, 8'h00, 16'd0, '0, 1'b0, 16'd13, '0, 1'b1);
    add_entry(KindRead, 8'h03, CmdIndirectData, 16'd0, '0, 1'b0, 16'd0, '0, 1'b1);
  endtask

  initial begin : main
    entry_t e;
    int     first_err;
    rst_n_i = 1'b0;
    dev_status_i = 8'h00;
    rx_valid_i = 1'b0;
    rx_data_i = 8'h00;
    bus_start_i = 1'b0;
    bus_stop_i = 1'b0;
    bus_addr_i = 8'h00;
    bus_addr_valid_i = 1'b0;
    tx_ready_i = 1'b0;
    tx_nack_i = 1'b0;
    payload_ready_i = 1'b0;
    build_table();
    repeat (ResetCycles) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    for (int i = 0; i < table_q.size(); i++) begin
      e = table_q[i];
      first_err = errors;
      if (dev_status_i != e.status) begin
        dev_status_i = e.status;
        @(negedge clk_i);
      end
      case (e.kind)
        KindWrite: run_write(e);
        KindRead:  run_read(e);
        default:   run_drain(e);
      endcase
      if (image_activated_o !== e.exp_active) begin
        $display("Fail at %0t: image_activated_o got %b expected %b", $time,
                 image_activated_o, e.exp_active);
        errors++;
      end
      if (errors == first_err) begin
        passed++;
      end
      $display("Entry %0d %s cmd %0d: %s", i, kind_name(e.kind), e.cmd,
               (errors == first_err) ? "ok" : "mismatch");
    end
    errors = errors + dut_i.sva_i.fail_count;
    $display("Entries ok %0d of %0d, errors %0d", passed, table_q.size(), errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== sim/recovery_handler_sva.sv ====
// Recovery handler stream assertions
`timescale 1ns/1ps

module recovery_handler_sva (
  input logic                clk_i,
  input logic                rst_n_i,
  input recovery_pkg::byte_t dev_status_i,
  input logic                bus_stop_i,
  input logic                tx_nack_i,
  input logic                tx_valid_i,
  input logic                tx_ready_i,
  input recovery_pkg::byte_t tx_data_i,
  input logic                payload_valid_i,
  input logic                payload_ready_i,
  input recovery_pkg::byte_t payload_data_i,
  input logic                payload_available_i,
  input logic                image_activated_i
);
  import recovery_pkg::*;

  int   fail_count = 0;
  logic mode_on;

  assign mode_on = (dev_status_i == RecoveryMode);

  // NACK or stop may legally cut a response short
  tx_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i || !mode_on)
    tx_valid_i && !tx_ready_i && !tx_nack_i && !bus_stop_i
    |=> tx_valid_i && $stable(tx_data_i))
    else begin
      fail_count++;
      $error("tx stream dropped valid or changed data before ready");
    end

  payload_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i || !mode_on)
    payload_valid_i && !payload_ready_i |=> payload_valid_i && $stable(payload_data_i))
    else begin
      fail_count++;
      $error("payload stream dropped valid or changed data before ready");
    end

  mode_off_quiet_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !mode_on |-> !tx_valid_i && !payload_valid_i && !payload_available_i &&
                 !image_activated_i)
    else begin
      fail_count++;
      $error("outputs active while recovery mode is off");
    end

endmodule

bind recovery_handler recovery_handler_sva sva_i (
  .clk_i              (clk_i),
  .rst_n_i            (rst_n_i),
  .dev_status_i       (dev_status_i),
  .bus_stop_i         (bus_stop_i),
  .tx_nack_i          (tx_nack_i),
  .tx_valid_i         (tx_valid_o),
  .tx_ready_i         (tx_ready_i),
  .tx_data_i          (tx_data_o),
  .payload_valid_i    (payload_valid_o),
  .payload_ready_i    (payload_ready_i),
  .payload_data_i     (payload_data_o),
  .payload_available_i(payload_available_o),
  .image_activated_i  (image_activated_o)
);

// ==== rtl/recovery_handler.sv ====
// I3C recovery protocol handler
`timescale 1ns/1ps

module recovery_handler (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  recovery_pkg::byte_t dev_status_i,
  input  logic                rx_valid_i,
  output logic                rx_ready_o,
  input  recovery_pkg::byte_t rx_data_i,
  input  logic                bus_start_i,
  input  logic                bus_stop_i,
  input  recovery_pkg::byte_t bus_addr_i,
  input  logic                bus_addr_valid_i,
  output logic                tx_valid_o,
  input  logic                tx_ready_i,
  output recovery_pkg::byte_t tx_data_o,
  input  logic                tx_nack_i,
  output logic                payload_valid_o,
  input  logic                payload_ready_i,
  output recovery_pkg::byte_t payload_data_o,
  output logic                payload_available_o,
  output logic                image_activated_o
);
  import recovery_pkg::*;

  logic recovery_enable;
  logic engine_rst_n;

  logic      rcv_ready;
  logic      rx_pec_en;
  byte_t     rx_crc;
  byte_t     rx_pec_data;
  logic      cmd_valid;
  logic      cmd_ready;
  rec_cmd_t  cmd;

  logic      resp_valid;
  logic      resp_ready;
  rec_resp_t resp;

  logic      xmit_valid;
  logic      tx_pec_en;
  byte_t     tx_crc;
  byte_t     tx_pec_data;
  logic      exec_payload_valid;
  logic      exec_image_activated;

  assign recovery_enable = (dev_status_i == RecoveryMode);
  assign engine_rst_n = rst_n_i && recovery_enable;

  // Outside recovery mode bytes are swallowed and outputs stay quiet
  assign rx_ready_o = recovery_enable ? rcv_ready : 1'b1;
  assign tx_valid_o = xmit_valid && recovery_enable;
  assign payload_valid_o = exec_payload_valid && recovery_enable;
  assign payload_available_o = payload_valid_o;
  assign image_activated_o = exec_image_activated && recovery_enable;

  // Address byte seeds the PEC
  assign rx_pec_data = bus_addr_valid_i ? bus_addr_i : rx_data_i;
  assign tx_pec_data = bus_addr_valid_i ? bus_addr_i : tx_data_o;

  recovery_pec rx_pec_i (
    .clk_i,
    .rst_n_i(engine_rst_n),
    .clear_i(bus_start_i),
    .init_i (bus_addr_valid_i),
    .valid_i(rx_pec_en),
    .data_i (rx_pec_data),
    .crc_o  (rx_crc)
  );

  recovery_pec tx_pec_i (
    .clk_i,
    .rst_n_i(engine_rst_n),
    .clear_i(bus_start_i),
    .init_i (bus_addr_valid_i),
    .valid_i(tx_pec_en),
    .data_i (tx_pec_data),
    .crc_o  (tx_crc)
  );

  recovery_receiver receiver_i (
    .clk_i,
    .rst_n_i    (engine_rst_n),
    .rx_valid_i,
    .rx_ready_o (rcv_ready),
    .rx_data_i,
    .bus_start_i,
    .bus_stop_i,
    .bus_addr_i,
    .bus_addr_valid_i,
    .pec_en_o   (rx_pec_en),
    .pec_crc_i  (rx_crc),
    .cmd_valid_o(cmd_valid),
    .cmd_ready_i(cmd_ready),
    .cmd_o      (cmd)
  );

  recovery_executor executor_i (
    .clk_i,
    .rst_n_i          (engine_rst_n),
    .cmd_valid_i      (cmd_valid),
    .cmd_ready_o      (cmd_ready),
    .cmd_i            (cmd),
    .resp_valid_o     (resp_valid),
    .resp_ready_i     (resp_ready),
    .resp_o           (resp),
    .payload_valid_o  (exec_payload_valid),
    .payload_ready_i,
    .payload_data_o,
    .image_activated_o(exec_image_activated)
  );

  recovery_transmitter transmitter_i (
    .clk_i,
    .rst_n_i     (engine_rst_n),
    .resp_valid_i(resp_valid),
    .resp_ready_o(resp_ready),
    .resp_i      (resp),
    .tx_valid_o  (xmit_valid),
    .tx_ready_i,
    .tx_data_o,
    .host_abort_i(tx_nack_i || bus_stop_i),
    .pec_en_o    (tx_pec_en),
    .pec_crc_i   (tx_crc)
  );

endmodule

// ==== rtl/recovery_transmitter.sv ====
// Recovery response transmitter
`timescale 1ns/1ps

module recovery_transmitter (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    resp_valid_i,
  output logic                    resp_ready_o,
  input  recovery_pkg::rec_resp_t resp_i,
  output logic                    tx_valid_o,
  input  logic                    tx_ready_i,
  output recovery_pkg::byte_t     tx_data_o,
  input  logic                    host_abort_i,
  output logic                    pec_en_o,
  input  recovery_pkg::byte_t     pec_crc_i
);
  import recovery_pkg::*;

  typedef enum logic [2:0] {
    T_IDLE,
    T_LEN_L,
    T_LEN_H,
    T_DATA,
    T_PEC
  } tx_state_e;

  tx_state_e state_q, state_d;

  rec_resp_t              resp_q;
  logic [PayloadIdxW-1:0] idx_q;

  logic tx_fire;
  logic data_last;

  assign resp_ready_o = (state_q == T_IDLE) && !host_abort_i;
  assign tx_valid_o = (state_q != T_IDLE);
  assign tx_fire = tx_valid_o && tx_ready_i;
  assign pec_en_o = tx_fire && (state_q != T_PEC);
  assign data_last = (rec_len_t'(idx_q) + rec_len_t'(1)) == resp_q.len;

  always_comb begin
    case (state_q)
      T_LEN_L: tx_data_o = resp_q.len[7:0];
      T_LEN_H: tx_data_o = resp_q.len[15:8];
      T_DATA:  tx_data_o = resp_q.data[8*idx_q +: 8];
      T_PEC:   tx_data_o = pec_crc_i;
      default: tx_data_o = '0;
    endcase
  end

  always_comb begin
    state_d = state_q;
    if (host_abort_i) begin
      // NACK or stop drops the rest of the response
      state_d = T_IDLE;
    end else begin
      case (state_q)
        T_IDLE: begin
          if (resp_valid_i) begin
            state_d = T_LEN_L;
          end
        end
        T_LEN_L: begin
          if (tx_ready_i) begin
            state_d = T_LEN_H;
          end
        end
        T_LEN_H: begin
          if (tx_ready_i) begin
            state_d = (resp_q.len == '0) ? T_PEC : T_DATA;
          end
        end
        T_DATA: begin
          if (tx_ready_i && data_last) begin
            state_d = T_PEC;
          end
        end
        T_PEC: begin
          if (tx_ready_i) begin
            state_d = T_IDLE;
          end
        end
        default: state_d = T_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= T_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (resp_valid_i && resp_ready_o) begin
      resp_q <= resp_i;
    end
    if (tx_fire && state_q == T_LEN_H) begin
      idx_q <= '0;
    end else if (tx_fire && state_q == T_DATA) begin
      idx_q <= idx_q + 1'b1;
    end
  end

endmodule

// ==== rtl/recovery_executor.sv ====
// Recovery command executor
`timescale 1ns/1ps

module recovery_executor (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    cmd_valid_i,
  output logic                    cmd_ready_o,
  input  recovery_pkg::rec_cmd_t  cmd_i,
  output logic                    resp_valid_o,
  input  logic                    resp_ready_i,
  output recovery_pkg::rec_resp_t resp_o,
  output logic                    payload_valid_o,
  input  logic                    payload_ready_i,
  output recovery_pkg::byte_t     payload_data_o,
  output logic                    image_activated_o
);
  import recovery_pkg::*;

  typedef enum logic {
    E_IDLE,
    E_RESP
  } exec_state_e;

  exec_state_e state_q;

  logic [8*RecoveryCtrlLen-1:0] ctrl_q;
  logic                         activated_q;
  logic [PayloadIdxW-1:0]       push_idx_q;
  rec_resp_t                    resp_q;
  rec_resp_t                    resp_d;

  logic  is_push;
  logic  push_last;
  logic  cmd_fire;
  logic  ctrl_wr;
  logic  fifo_wr_valid;
  logic  fifo_wr_ready;
  byte_t fifo_wr_data;

  assign is_push = !cmd_i.is_rd && (cmd_i.cmd == CmdIndirectData) && (cmd_i.len != '0);
  assign push_last = (rec_len_t'(push_idx_q) + rec_len_t'(1)) == cmd_i.len;

  // Image bytes go out one per cycle, command completes with the last one
  assign fifo_wr_valid = (state_q == E_IDLE) && cmd_valid_i && is_push;
  assign fifo_wr_data = cmd_i.data[8*push_idx_q +: 8];

  always_comb begin
    cmd_ready_o = 1'b0;
    if (state_q == E_IDLE) begin
      cmd_ready_o = is_push ? (fifo_wr_ready && push_last) : 1'b1;
    end
  end

  assign cmd_fire = cmd_valid_i && cmd_ready_o;
  assign ctrl_wr = cmd_fire && !cmd_i.is_rd && (cmd_i.cmd == CmdRecoveryCtrl) &&
                   (cmd_i.len == RecoveryCtrlLen);

  // Read responses
  always_comb begin
    resp_d = '0;
    case (cmd_i.cmd)
      CmdProtCap: begin
        resp_d.len = rec_len_t'($bits(ProtCapValue) / 8);
        resp_d.data = ProtCapValue;
      end
      CmdRecoveryCtrl: begin
        resp_d.len = RecoveryCtrlLen;
        resp_d.data = rec_payload_t'(ctrl_q);
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= E_IDLE;
      ctrl_q <= '0;
      activated_q <= 1'b0;
      push_idx_q <= '0;
    end else begin
      case (state_q)
        E_IDLE: begin
          if (cmd_fire && cmd_i.is_rd) begin
            state_q <= E_RESP;
          end
        end
        E_RESP: begin
          if (resp_ready_i) begin
            state_q <= E_IDLE;
          end
        end
        default: state_q <= E_IDLE;
      endcase
      if (fifo_wr_valid && fifo_wr_ready) begin
        push_idx_q <= push_last ? '0 : push_idx_q + 1'b1;
      end
      if (ctrl_wr) begin
        ctrl_q <= cmd_i.data[8*RecoveryCtrlLen-1:0];
        if (cmd_i.data[23:16] == ImageActivate) begin
          activated_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_fire && cmd_i.is_rd) begin
      resp_q <= resp_d;
    end
  end

  assign resp_valid_o = (state_q == E_RESP);
  assign resp_o = resp_q;
  assign image_activated_o = activated_q;

  payload_fifo #(
    .Depth(PayloadDepth)
  ) payload_fifo_i (
    .clk_i,
    .rst_n_i,
    .wr_valid_i(fifo_wr_valid),
    .wr_ready_o(fifo_wr_ready),
    .wr_data_i (fifo_wr_data),
    .rd_valid_o(payload_valid_o),
    .rd_ready_i(payload_ready_i),
    .rd_data_o (payload_data_o)
  );

endmodule

// ==== rtl/recovery_receiver.sv ====
// Recovery packet receiver
`timescale 1ns/1ps

module recovery_receiver (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   rx_valid_i,
  output logic                   rx_ready_o,
  input  recovery_pkg::byte_t    rx_data_i,
  input  logic                   bus_start_i,
  input  logic                   bus_stop_i,
  input  recovery_pkg::byte_t    bus_addr_i,
  input  logic                   bus_addr_valid_i,
  output logic                   pec_en_o,
  input  recovery_pkg::byte_t    pec_crc_i,
  output logic                   cmd_valid_o,
  input  logic                   cmd_ready_i,
  output recovery_pkg::rec_cmd_t cmd_o
);
  import recovery_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_CMD,
    S_LEN_L,
    S_LEN_H,
    S_DATA,
    S_PEC,
    S_OFFER
  } rx_state_e;

  rx_state_e state_q, state_d;

  logic                   is_rd_q;
  byte_t                  cmd_q;
  rec_len_t               len_q;
  rec_payload_t           data_q;
  logic [PayloadIdxW-1:0] idx_q;

  logic     byte_acc;
  logic     data_last;
  rec_len_t len_next;

  assign rx_ready_o = (state_q != S_OFFER);
  assign byte_acc = rx_valid_i && rx_ready_o && !bus_addr_valid_i && !bus_stop_i &&
                    !bus_start_i;
  assign len_next = {rx_data_i, len_q[7:0]};
  assign data_last = (rec_len_t'(idx_q) + rec_len_t'(1)) == len_q;

  // Every byte ahead of the PEC goes into the checksum
  assign pec_en_o = byte_acc && (state_q inside {S_CMD, S_LEN_L, S_LEN_H, S_DATA});

  always_comb begin
    state_d = state_q;
    if (state_q == S_OFFER) begin
      if (cmd_ready_i) begin
        state_d = S_IDLE;
      end
    end else if (bus_addr_valid_i) begin
      // Read address right after a lone command byte makes a read request
      if (!bus_addr_i[0]) begin
        state_d = S_CMD;
      end else if (state_q == S_LEN_L) begin
        state_d = S_OFFER;
      end else begin
        state_d = S_IDLE;
      end
    end else if (bus_stop_i || (bus_start_i && state_q != S_LEN_L)) begin
      state_d = S_IDLE;
    end else if (byte_acc) begin
      case (state_q)
        S_CMD:   state_d = S_LEN_L;
        S_LEN_L: state_d = S_LEN_H;
        S_LEN_H: begin
          if (len_next > rec_len_t'(MaxPayload)) begin
            state_d = S_IDLE;
          end else if (len_next == '0) begin
            state_d = S_PEC;
          end else begin
            state_d = S_DATA;
          end
        end
        S_DATA: begin
          if (data_last) begin
            state_d = S_PEC;
          end
        end
        S_PEC:   state_d = (rx_data_i == pec_crc_i) ? S_OFFER : S_IDLE;
        default: state_d = state_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Packet fields
  always_ff @(posedge clk_i) begin
    if (state_q != S_OFFER && state_d == S_OFFER) begin
      is_rd_q <= bus_addr_valid_i;
    end
    if (byte_acc) begin
      case (state_q)
        S_CMD: begin
          cmd_q <= rx_data_i;
          len_q <= '0;
        end
        S_LEN_L: len_q[7:0] <= rx_data_i;
        S_LEN_H: begin
          len_q[15:8] <= rx_data_i;
          idx_q <= '0;
        end
        S_DATA: begin
          data_q[8*idx_q +: 8] <= rx_data_i;
          idx_q <= idx_q + 1'b1;
        end
        default: ;
      endcase
    end
  end

  assign cmd_valid_o = (state_q == S_OFFER);
  assign cmd_o.is_rd = is_rd_q;
  assign cmd_o.cmd = cmd_q;
  assign cmd_o.len = len_q;
  assign cmd_o.data = data_q;

endmodule

// ==== rtl/payload_fifo.sv ====
// Image payload byte FIFO
`timescale 1ns/1ps

module payload_fifo #(
  parameter int unsigned Depth = recovery_pkg::PayloadDepth
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                wr_valid_i,
  output logic                wr_ready_o,
  input  recovery_pkg::byte_t wr_data_i,
  output logic                rd_valid_o,
  input  logic                rd_ready_i,
  output recovery_pkg::byte_t rd_data_o
);
  import recovery_pkg::*;

  byte_t                    mem_q [Depth];
  logic [$clog2(Depth)-1:0] wr_ptr_q;
  logic [$clog2(Depth)-1:0] rd_ptr_q;
  logic [$clog2(Depth):0]   count_q;

  logic push;
  logic pop;

  assign wr_ready_o = (count_q != ($clog2(Depth) + 1)'(Depth));
  assign rd_valid_o = (count_q != '0);
  assign rd_data_o = mem_q[rd_ptr_q];
  assign push = wr_valid_i && wr_ready_o;
  assign pop = rd_valid_o && rd_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == $clog2(Depth)'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == $clog2(Depth)'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keep the count
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wr_data_i;
    end
  end

endmodule

// ==== rtl/recovery_pec.sv ====
// SMBus PEC accumulator
`timescale 1ns/1ps

module recovery_pec (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                clear_i,
  input  logic                init_i,
  input  logic                valid_i,
  input  recovery_pkg::byte_t data_i,
  output recovery_pkg::byte_t crc_o
);
  import recovery_pkg::*;

  byte_t crc_q;

  // CRC-8, polynomial x^8 + x^2 + x + 1, MSB first
  function automatic byte_t crc8_step(byte_t crc, byte_t data);
    byte_t c;
    c = crc ^ data;
    for (int i = 0; i < 8; i++) begin
      c = c[7] ? ((c << 1) ^ 8'h07) : (c << 1);
    end
    return c;
  endfunction

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      crc_q <= '0;
    end else if (init_i) begin
      crc_q <= crc8_step('0, data_i);
    end else if (clear_i) begin
      crc_q <= '0;
    end else if (valid_i) begin
      crc_q <= crc8_step(crc_q, data_i);
    end
  end

  assign crc_o = crc_q;

endmodule

// ==== rtl/recovery_pkg.sv ====
// Recovery handler shared definitions
package recovery_pkg;

  // Bus and packet field types
  typedef logic [7:0] byte_t;
  typedef logic [15:0] rec_len_t;

  localparam int unsigned MaxPayload = 8;
  localparam int unsigned PayloadIdxW = $clog2(MaxPayload);

  typedef logic [8*MaxPayload-1:0] rec_payload_t;

  // Device status value that enables the handler
  localparam byte_t RecoveryMode = 8'h03;

  // Supported command codes
  localparam byte_t CmdProtCap = 8'd34;
  localparam byte_t CmdRecoveryCtrl = 8'd38;
  localparam byte_t CmdIndirectData = 8'd43;

  localparam rec_len_t RecoveryCtrlLen = 16'd3;
  localparam byte_t ImageActivate = 8'h0F;

  // "OCP RECV", byte 0 in the low bits
  localparam rec_payload_t ProtCapValue = 64'h5643_4552_2050_434F;

  localparam int unsigned PayloadDepth = 16;

  // Checked command from receiver to executor
  typedef struct packed {
    logic         is_rd;
    byte_t        cmd;
    rec_len_t     len;
    rec_payload_t data;
  } rec_cmd_t;

  // Read response from executor to transmitter
  typedef struct packed {
    rec_len_t     len;
    rec_payload_t data;
  } rec_resp_t;

endpackage
